// ==== logic/mem_defines.svh ====
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

////////////////////
// widths

`define REG_W       32
`define ADDR_W      12   // byte address.
`define OP_W        8
`define RADDR_W     5

`define RAM_WORDS   1024 // covers the whole byte address space.

////////////////////
// opcodes

`define EXE_ALU_OP   8'h01 // result passes through.
`define EXE_LD_B_OP  8'h10
`define EXE_LD_BU_OP 8'h11
`define EXE_LD_H_OP  8'h12
`define EXE_LD_W_OP  8'h14
`define EXE_LL_OP    8'h15
`define EXE_ST_B_OP  8'h18
`define EXE_ST_H_OP  8'h19
`define EXE_ST_W_OP  8'h1a

////////////////////
// flow control

`define MEM_CREDITS    4 // queue depth, also issuer credits.
`define WB_CREDITS_MAX 8

`endif

// ==== logic/mem_pkg.sv ====
`include "mem_defines.svh"

package mem_pkg;

    // data word.
    typedef logic [`REG_W-1:0] word_t;

    // byte address into the data RAM.
    typedef logic [`ADDR_W-1:0] addr_t;

    // execute opcode.
    typedef logic [`OP_W-1:0] aluop_t;

    // register file index.
    typedef logic [`RADDR_W-1:0] raddr_t;

    // one enable per byte lane.
    typedef logic [3:0] be_t;

endpackage

// ==== logic/mem1_stage.sv ====
`timescale 1ns/1ps
`include "mem_defines.svh"

module mem1_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid_i,
    input  mem_pkg::aluop_t     in_aluop_i,
    input  logic                in_wreg_i,
    input  mem_pkg::raddr_t     in_waddr_i,
    input  mem_pkg::word_t      in_wdata_i,
    input  mem_pkg::addr_t      in_addr_i,
    input  mem_pkg::word_t      in_sdata_i,
    output logic                ram_en_o,
    output mem_pkg::be_t        ram_we_o,
    output logic [`ADDR_W-3:0]  ram_addr_o,
    output mem_pkg::word_t      ram_wdata_o,
    output logic                m2_valid_o,
    output mem_pkg::aluop_t     m2_aluop_o,
    output logic                m2_wreg_o,
    output mem_pkg::raddr_t     m2_waddr_o,
    output mem_pkg::word_t      m2_wdata_o,
    output mem_pkg::addr_t      m2_addr_o
);
    import mem_pkg::*;

    logic   m1_valid;
    aluop_t m1_aluop;
    logic   m1_wreg;
    raddr_t m1_waddr;
    word_t  m1_wdata;
    addr_t  m1_addr;
    word_t  m1_sdata;
    logic   is_load;
    logic   is_store;
    be_t    st_be;
    word_t  st_data;

    ////////////////////
    // mem1 register

    always_ff @(posedge clk) begin
        if (rst) begin
            m1_valid <= 1'b0;
        end else begin
            m1_valid <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        m1_aluop <= in_aluop_i;
        m1_wreg  <= in_wreg_i;
        m1_waddr <= in_waddr_i;
        m1_wdata <= in_wdata_i;
        m1_addr  <= in_addr_i;
        m1_sdata <= in_sdata_i;
    end

    ////////////////////
    // RAM request

    assign is_load  = m1_aluop inside {`EXE_LD_B_OP, `EXE_LD_BU_OP, `EXE_LD_H_OP,
                                       `EXE_LD_W_OP, `EXE_LL_OP};
    assign is_store = m1_aluop inside {`EXE_ST_B_OP, `EXE_ST_H_OP, `EXE_ST_W_OP};

    always_comb begin
        st_be   = '0;
        st_data = m1_sdata;
        case (m1_aluop)
            `EXE_ST_B_OP: begin
                st_be   = 4'b0001 << m1_addr[1:0];
                st_data = {4{m1_sdata[7:0]}}; // same byte on every lane.
            end
            `EXE_ST_H_OP: begin
                if (!m1_addr[0]) begin
                    st_be = m1_addr[1] ? 4'b1100 : 4'b0011;
                end
                st_data = {2{m1_sdata[15:0]}};
            end
            `EXE_ST_W_OP: begin
                if (m1_addr[1:0] == 2'b00) begin
                    st_be = 4'b1111;
                end
            end
            default: ;
        endcase
    end

    // misaligned stores drop out here with empty enables.
    assign ram_en_o    = m1_valid & (is_load | (is_store & (|st_be)));
    assign ram_we_o    = m1_valid ? st_be : 4'b0000;
    assign ram_addr_o  = m1_addr[`ADDR_W-1:2]; // word index.
    assign ram_wdata_o = st_data;

    ////////////////////
    // mem2 slot

    always_ff @(posedge clk) begin
        if (rst) begin
            m2_valid_o <= 1'b0;
        end else begin
            m2_valid_o <= m1_valid;
        end
    end

    always_ff @(posedge clk) begin
        m2_aluop_o <= m1_aluop;
        m2_wreg_o  <= m1_wreg;
        m2_waddr_o <= m1_waddr;
        m2_wdata_o <= m1_wdata;
        m2_addr_o  <= m1_addr;
    end

    a_known_op: assert property (@(posedge clk) disable iff (rst)
        in_valid_i |-> in_aluop_i inside {`EXE_ALU_OP, `EXE_LD_B_OP, `EXE_LD_BU_OP,
                                          `EXE_LD_H_OP, `EXE_LD_W_OP, `EXE_LL_OP,
                                          `EXE_ST_B_OP, `EXE_ST_H_OP, `EXE_ST_W_OP})
        else $error("mem1_stage: undefined opcode %h issued", in_aluop_i);

endmodule

// ==== logic/data_ram.sv ====
`timescale 1ns/1ps
`include "mem_defines.svh"

module data_ram (
    input  logic                clk,
    input  logic                rst,
    input  logic                ram_en_i,
    input  mem_pkg::be_t        ram_we_i,
    input  logic [`ADDR_W-3:0]  ram_addr_i,
    input  mem_pkg::word_t      ram_wdata_i,
    output mem_pkg::word_t      ram_rdata_o,
    output logic                data_ok_o
);
    import mem_pkg::*;

    word_t mem [`RAM_WORDS];
    logic  rd_req;

    assign rd_req = ram_en_i & (ram_we_i == 4'b0000);

    ////////////////////
    // storage

    always_ff @(posedge clk) begin
        if (ram_en_i) begin
            for (int i = 0; i < 4; i++) begin
                if (ram_we_i[i]) begin
                    mem[ram_addr_i][i*8 +: 8] <= ram_wdata_i[i*8 +: 8]; // byte lane.
                end
            end
        end
    end

    // read data holds between reads.
    always_ff @(posedge clk) begin
        if (rd_req) begin
            ram_rdata_o <= mem[ram_addr_i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            data_ok_o <= 1'b0;
        end else begin
            data_ok_o <= rd_req; // one cycle pulse per read.
        end
    end

    a_we_with_en: assert property (@(posedge clk) disable iff (rst)
        (ram_we_i != 4'b0000) |-> ram_en_i)
        else $error("data_ram: byte enables raised without ram_en");

endmodule

// ==== logic/mem2_stage.sv ====
`timescale 1ns/1ps
`include "mem_defines.svh"

module mem2_stage (
    input  logic            m2_valid_i,
    input  mem_pkg::aluop_t m2_aluop_i,
    input  logic            m2_wreg_i,
    input  mem_pkg::raddr_t m2_waddr_i,
    input  mem_pkg::word_t  m2_wdata_i,
    input  mem_pkg::addr_t  m2_addr_i,
    input  logic            data_ok_i,
    input  mem_pkg::word_t  cache_data_i,
    output logic            r_valid_o,
    output logic            r_wreg_o,
    output mem_pkg::raddr_t r_waddr_o,
    output mem_pkg::word_t  r_wdata_o,
    output logic            fwd_load_o,
    output logic            fwd_ready_o,
    output logic            fwd_wreg_o,
    output mem_pkg::raddr_t fwd_waddr_o,
    output mem_pkg::word_t  fwd_wdata_o
);
    import mem_pkg::*;

    logic        is_load;
    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    word_t       ld_data;

    assign is_load = m2_aluop_i inside {`EXE_LD_B_OP, `EXE_LD_BU_OP, `EXE_LD_H_OP,
                                        `EXE_LD_W_OP, `EXE_LL_OP};

    ////////////////////
    // lane select

    always_comb begin
        case (m2_addr_i[1:0])
            2'b00:   byte_sel = cache_data_i[7:0];
            2'b01:   byte_sel = cache_data_i[15:8];
            2'b10:   byte_sel = cache_data_i[23:16];
            default: byte_sel = cache_data_i[31:24];
        endcase
    end

    assign half_sel = m2_addr_i[1] ? cache_data_i[31:16] : cache_data_i[15:0];

    // non-loads keep their execute result.
    always_comb begin
        ld_data = m2_wdata_i;
        if (is_load && data_ok_i) begin
            case (m2_aluop_i)
                `EXE_LD_B_OP:  ld_data = {{(`REG_W-8){byte_sel[7]}}, byte_sel};
                `EXE_LD_BU_OP: ld_data = {{(`REG_W-8){1'b0}}, byte_sel};
                `EXE_LD_H_OP: begin
                    if (m2_addr_i[0]) begin
                        ld_data = '0; // odd half address reads as zero.
                    end else begin
                        ld_data = {{(`REG_W-16){half_sel[15]}}, half_sel};
                    end
                end
                `EXE_LD_W_OP,
                `EXE_LL_OP:    ld_data = cache_data_i;
                default: ;
            endcase
        end
    end

    assign r_valid_o = m2_valid_i;
    assign r_wreg_o  = m2_wreg_i;
    assign r_waddr_o = m2_waddr_i;
    assign r_wdata_o = ld_data;

    ////////////////////
    // forwarding

    assign fwd_load_o  = m2_valid_i & is_load;
    assign fwd_ready_o = m2_valid_i & (~is_load | data_ok_i);
    assign fwd_wreg_o  = m2_valid_i & m2_wreg_i;
    assign fwd_waddr_o = m2_waddr_i;
    assign fwd_wdata_o = ld_data;

    // a load slot never waits for its data.
    always_comb begin
        if (m2_valid_i && is_load) begin
            a_load_has_data: assert (data_ok_i)
                else $error("mem2_stage: load slot without data_ok");
        end
    end

endmodule

// ==== logic/result_fifo.sv ====
`timescale 1ns/1ps
`include "mem_defines.svh"

module result_fifo (
    input  logic            clk,
    input  logic            rst,
    input  logic            r_valid_i,
    input  logic            r_wreg_i,
    input  mem_pkg::raddr_t r_waddr_i,
    input  mem_pkg::word_t  r_wdata_i,
    input  logic            wb_credit_i,
    output logic            wb_valid_o,
    output mem_pkg::raddr_t wb_waddr_o,
    output mem_pkg::word_t  wb_wdata_o,
    output logic            credit_o
);
    import mem_pkg::*;

    localparam int PTR_W  = $clog2(`MEM_CREDITS);
    localparam int FILL_W = PTR_W + 1;
    localparam int CNT_W  = $clog2(`WB_CREDITS_MAX + 1);

    raddr_t            q_waddr [`MEM_CREDITS];
    word_t             q_wdata [`MEM_CREDITS];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [FILL_W-1:0] fill;
    logic [CNT_W-1:0]  wb_cnt;
    logic              push;
    logic              no_wreg;
    logic              send;
    logic              pend_q;

    assign push    = r_valid_i & r_wreg_i;
    assign no_wreg = r_valid_i & ~r_wreg_i;
    // hold the send when it would make a third credit in one cycle.
    assign send    = (wb_cnt != '0) && (fill != '0) && !(pend_q && no_wreg);

    always_ff @(posedge clk) begin
        if (push) begin
            q_waddr[wr_ptr] <= r_waddr_i;
            q_wdata[wr_ptr] <= r_wdata_i;
        end
        if (send) begin
            wb_waddr_o <= q_waddr[rd_ptr];
            wb_wdata_o <= q_wdata[rd_ptr];
        end
    end

    ////////////////////
    // pointers and credits

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill       <= '0;
            wb_cnt     <= '0;
            wb_valid_o <= 1'b0;
            credit_o   <= 1'b0;
            pend_q     <= 1'b0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (send) rd_ptr <= rd_ptr + 1'b1;
            fill       <= fill + FILL_W'(push) - FILL_W'(send);
            wb_cnt     <= wb_cnt + CNT_W'(wb_credit_i) - CNT_W'(send);
            wb_valid_o <= send;
            credit_o   <= send | no_wreg | pend_q;
            pend_q     <= (send & no_wreg) | (pend_q & (send | no_wreg)); // surplus credit.
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        push |-> fill != FILL_W'(`MEM_CREDITS))
        else $error("result_fifo: push into a full queue");

    a_cnt_bound: assert property (@(posedge clk) disable iff (rst)
        (wb_credit_i && !send) |-> wb_cnt < CNT_W'(`WB_CREDITS_MAX))
        else $error("result_fifo: writeback credit counter overflow");

endmodule

// ==== logic/mem_top.sv ====
`timescale 1ns/1ps
`include "mem_defines.svh"

module mem_top (
    input  logic            clk,
    input  logic            rst,
    input  logic            in_valid_i,
    input  mem_pkg::aluop_t in_aluop_i,
    input  logic            in_wreg_i,
    input  mem_pkg::raddr_t in_waddr_i,
    input  mem_pkg::word_t  in_wdata_i,
    input  mem_pkg::addr_t  in_addr_i,
    input  mem_pkg::word_t  in_sdata_i,
    output logic            credit_o,
    input  logic            wb_credit_i,
    output logic            wb_valid_o,
    output mem_pkg::raddr_t wb_waddr_o,
    output mem_pkg::word_t  wb_wdata_o,
    output logic            fwd_load_o,
    output logic            fwd_ready_o,
    output logic            fwd_wreg_o,
    output mem_pkg::raddr_t fwd_waddr_o,
    output mem_pkg::word_t  fwd_wdata_o
);
    import mem_pkg::*;

    logic               ram_en;
    be_t                ram_we;
    logic [`ADDR_W-3:0] ram_addr;
    word_t              ram_wdata;
    word_t              ram_rdata;
    logic               data_ok;
    logic               m2_valid;
    aluop_t             m2_aluop;
    logic               m2_wreg;
    raddr_t             m2_waddr;
    word_t              m2_wdata;
    addr_t              m2_addr;
    logic               r_valid;
    logic               r_wreg;
    raddr_t             r_waddr;
    word_t              r_wdata;

    mem1_stage u_mem1 (
        .clk(clk), .rst(rst),
        .in_valid_i(in_valid_i), .in_aluop_i(in_aluop_i), .in_wreg_i(in_wreg_i),
        .in_waddr_i(in_waddr_i), .in_wdata_i(in_wdata_i), .in_addr_i(in_addr_i),
        .in_sdata_i(in_sdata_i),
        .ram_en_o(ram_en), .ram_we_o(ram_we), .ram_addr_o(ram_addr), .ram_wdata_o(ram_wdata),
        .m2_valid_o(m2_valid), .m2_aluop_o(m2_aluop), .m2_wreg_o(m2_wreg),
        .m2_waddr_o(m2_waddr), .m2_wdata_o(m2_wdata), .m2_addr_o(m2_addr)
    );

    data_ram u_ram (
        .clk(clk), .rst(rst),
        .ram_en_i(ram_en), .ram_we_i(ram_we), .ram_addr_i(ram_addr), .ram_wdata_i(ram_wdata),
        .ram_rdata_o(ram_rdata), .data_ok_o(data_ok)
    );

    mem2_stage u_mem2 (
        .m2_valid_i(m2_valid), .m2_aluop_i(m2_aluop), .m2_wreg_i(m2_wreg),
        .m2_waddr_i(m2_waddr), .m2_wdata_i(m2_wdata), .m2_addr_i(m2_addr),
        .data_ok_i(data_ok), .cache_data_i(ram_rdata),
        .r_valid_o(r_valid), .r_wreg_o(r_wreg), .r_waddr_o(r_waddr), .r_wdata_o(r_wdata),
        .fwd_load_o(fwd_load_o), .fwd_ready_o(fwd_ready_o), .fwd_wreg_o(fwd_wreg_o),
        .fwd_waddr_o(fwd_waddr_o), .fwd_wdata_o(fwd_wdata_o)
    );

    result_fifo u_fifo (
        .clk(clk), .rst(rst),
        .r_valid_i(r_valid), .r_wreg_i(r_wreg), .r_waddr_i(r_waddr), .r_wdata_i(r_wdata),
        .wb_credit_i(wb_credit_i),
        .wb_valid_o(wb_valid_o), .wb_waddr_o(wb_waddr_o), .wb_wdata_o(wb_wdata_o),
        .credit_o(credit_o)
    );

endmodule

// ==== tests/mem_tb.sv ====
`timescale 1ns/1ps
`include "mem_defines.svh"

module mem_tb;
    import mem_pkg::*;

    localparam int N_FILL      = 64;
    localparam int N_DIRECTED  = 82;
    localparam int N_DRAIN     = 6;
    localparam int N_RAND      = 300;
    localparam int TOTAL_OPS   = N_FILL + N_DIRECTED + N_DRAIN + `MEM_CREDITS + N_RAND;
    localparam int CYCLE_LIMIT = 20 * TOTAL_OPS + 200;

    logic   clk;
    logic   rst;
    logic   in_valid_i;
    aluop_t in_aluop_i;
    logic   in_wreg_i;
    raddr_t in_waddr_i;
    word_t  in_wdata_i;
    addr_t  in_addr_i;
    word_t  in_sdata_i;
    logic   credit_o;
    logic   wb_credit_i;
    logic   wb_valid_o;
    raddr_t wb_waddr_o;
    word_t  wb_wdata_o;
    logic   fwd_load_o;
    logic   fwd_ready_o;
    logic   fwd_wreg_o;
    raddr_t fwd_waddr_o;
    word_t  fwd_wdata_o;

    logic [7:0] shadow [256]; // low 64 words of the data RAM.
    raddr_t     exp_waddr [$];
    word_t      exp_wdata [$];
    raddr_t     fwd_waddr_q [$];
    word_t      fwd_wdata_q [$];
    logic       fwd_load_q [$];

    int   seed;
    int   credits = `MEM_CREDITS;
    int   issued = 0;
    int   credit_pulses = 0;
    int   grants = 0;
    int   beats = 0;
    int   fwd_checks = 0;
    int   errors = 0;
    int   cycles = 0;
    logic wb_pause;

    mem_top UUT (
        .clk(clk), .rst(rst),
        .in_valid_i(in_valid_i), .in_aluop_i(in_aluop_i), .in_wreg_i(in_wreg_i),
        .in_waddr_i(in_waddr_i), .in_wdata_i(in_wdata_i), .in_addr_i(in_addr_i),
        .in_sdata_i(in_sdata_i),
        .credit_o(credit_o), .wb_credit_i(wb_credit_i),
        .wb_valid_o(wb_valid_o), .wb_waddr_o(wb_waddr_o), .wb_wdata_o(wb_wdata_o),
        .fwd_load_o(fwd_load_o), .fwd_ready_o(fwd_ready_o), .fwd_wreg_o(fwd_wreg_o),
        .fwd_waddr_o(fwd_waddr_o), .fwd_wdata_o(fwd_wdata_o)
    );

    always #2 clk = ~clk;

    ////////////////////
    // reference model

    function automatic word_t ref_mem(aluop_t op, logic [7:0] a, word_t alu_res);
        logic [7:0]  b;
        logic [7:0]  w;
        logic [15:0] h;
        b = shadow[a];
        w = {a[7:2], 2'b00}; // word base.
        h = {shadow[a + 8'd1], shadow[a]};
        case (op)
            `EXE_LD_B_OP:  return {{24{b[7]}}, b};
            `EXE_LD_BU_OP: return {24'h0, b};
            `EXE_LD_H_OP:  return a[0] ? 32'h0 : {{16{h[15]}}, h};
            `EXE_LD_W_OP,
            `EXE_LL_OP:    return {shadow[w + 8'd3], shadow[w + 8'd2],
                                   shadow[w + 8'd1], shadow[w]};
            default:       return alu_res;
        endcase
    endfunction

    task automatic apply_store(aluop_t op, logic [7:0] a, word_t d);
        case (op)
            `EXE_ST_B_OP: shadow[a] = d[7:0];
            `EXE_ST_H_OP: begin
                if (!a[0]) begin
                    shadow[a]        = d[7:0];
                    shadow[a + 8'd1] = d[15:8];
                end
            end
            `EXE_ST_W_OP: begin
                if (a[1:0] == 2'b00) begin
                    for (int i = 0; i < 4; i++) begin
                        shadow[a + 8'(i)] = d[i*8 +: 8]; // little endian.
                    end
                end
            end
            default: ;
        endcase
    endtask

    ////////////////////
    // drivers

    task automatic grant_wb_credit();
        if (!wb_pause && (grants - beats) < 6 && ($random(seed) & 3) != 0) begin
            wb_credit_i <= 1'b1;
            grants++;
        end else begin
            wb_credit_i <= 1'b0;
        end
    endtask

    task automatic idle_cycles(int n);
        repeat (n) begin
            @(posedge clk);
            in_valid_i <= 1'b0;
            grant_wb_credit();
        end
    endtask

    task automatic wait_credits(int n);
        while (credits < n) begin
            idle_cycles(1);
        end
    endtask

    task automatic issue_op(aluop_t op, logic wreg, logic [7:0] a, word_t sdata);
        word_t  res;
        raddr_t dst;
        word_t  want;
        logic   ld;
        res = word_t'($random(seed));
        dst = raddr_t'($random(seed));
        ld  = op inside {`EXE_LD_B_OP, `EXE_LD_BU_OP, `EXE_LD_H_OP, `EXE_LD_W_OP, `EXE_LL_OP};
        @(posedge clk);
        while (credits == 0) begin
            in_valid_i <= 1'b0;
            grant_wb_credit();
            @(posedge clk);
        end
        credits--;
        issued++;
        in_valid_i <= 1'b1;
        in_aluop_i <= op;
        in_wreg_i  <= wreg;
        in_waddr_i <= dst;
        in_wdata_i <= res;
        in_addr_i  <= {4'h0, a};
        in_sdata_i <= sdata;
        grant_wb_credit();
        apply_store(op, a, sdata);
        if (wreg) begin
            want = ref_mem(op, a, res);
            exp_waddr.push_back(dst);
            exp_wdata.push_back(want);
            fwd_waddr_q.push_back(dst);
            fwd_wdata_q.push_back(want);
            fwd_load_q.push_back(ld);
        end
    endtask

    task automatic print_summary();
        $display("%0d ops issued, %0d writebacks, %0d forwards checked, %0d errors",
                 issued, beats, fwd_checks, errors);
    endtask

    ////////////////////
    // checker

    always @(negedge clk) begin : check_outputs
        raddr_t want_addr;
        word_t  want_data;
        logic   want_load;
        if (!rst) begin
            if (credit_o) begin
                credits++;
                credit_pulses++;
                if (credits > `MEM_CREDITS) begin
                    $display("ERROR: issue credit returned with none outstanding at %0t", $time);
                    errors++;
                end
            end
            if (wb_valid_o) begin
                beats++;
                if (beats > grants) begin
                    $display("ERROR: writeback beat without a granted credit at %0t", $time);
                    errors++;
                end
                if (exp_waddr.size() == 0) begin
                    $display("ERROR: writeback beat with no result expected at %0t", $time);
                    errors++;
                end else begin
                    want_addr = exp_waddr.pop_front();
                    want_data = exp_wdata.pop_front();
                    if (wb_waddr_o !== want_addr) begin
                        $display("FAIL wb_waddr_o got %h expected %h", wb_waddr_o, want_addr);
                        errors++;
                    end
                    if (wb_wdata_o !== want_data) begin
                        $display("FAIL wb_wdata_o got %h expected %h", wb_wdata_o, want_data);
                        errors++;
                    end
                end
            end
            if (fwd_wreg_o) begin
                if (fwd_waddr_q.size() == 0) begin
                    $display("ERROR: forwarding bundle shows an unexpected result at %0t", $time);
                    errors++;
                end else begin
                    want_addr = fwd_waddr_q.pop_front();
                    want_data = fwd_wdata_q.pop_front();
                    want_load = fwd_load_q.pop_front();
                    if (fwd_load_o !== want_load) begin
                        $display("FAIL fwd_load_o got %h expected %h", fwd_load_o, want_load);
                        errors++;
                    end
                    // the RAM answers in one cycle, so every slot is ready.
                    if (fwd_ready_o !== 1'b1) begin
                        $display("FAIL fwd_ready_o got %h expected %h", fwd_ready_o, 1'b1);
                        errors++;
                    end
                    if (fwd_load_o && fwd_ready_o) begin
                        fwd_checks++;
                        if (fwd_waddr_o !== want_addr) begin
                            $display("FAIL fwd_waddr_o got %h expected %h", fwd_waddr_o, want_addr);
                            errors++;
                        end
                        if (fwd_wdata_o !== want_data) begin
                            $display("FAIL fwd_wdata_o got %h expected %h", fwd_wdata_o, want_data);
                            errors++;
                        end
                    end
                end
            end
        end
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            if (exp_waddr.size() != 0) begin
                $display("ERROR: timeout with %0d results never written back", exp_waddr.size());
            end else if (credits != `MEM_CREDITS) begin
                $display("ERROR: timeout with %0d issue credits never returned",
                         `MEM_CREDITS - credits);
            end else begin
                $display("ERROR: timeout before the test sequence ended");
            end
            errors++;
            print_summary();
            $display("Simulation failed");
            $finish;
        end
    end

    ////////////////////
    // stimulus

    initial begin
        logic [7:0] a;
        aluop_t     op;
        logic       wr;
        seed        = 32'hf123_effe;
        clk         = 1'b0;
        rst         = 1'b1;
        in_valid_i  = 1'b0;
        in_aluop_i  = `EXE_ALU_OP;
        in_wreg_i   = 1'b0;
        in_waddr_i  = '0;
        in_wdata_i  = '0;
        in_addr_i   = '0;
        in_sdata_i  = '0;
        wb_credit_i = 1'b0;
        wb_pause    = 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // every word gets known data first.
        for (int w = 0; w < N_FILL; w++) begin
            issue_op(`EXE_ST_W_OP, 1'b0, 8'(w * 4), word_t'($random(seed)));
        end

        for (int w = 0; w < 4; w++) begin
            for (int off = 0; off < 4; off++) begin
                issue_op(`EXE_LD_B_OP, 1'b1, 8'(w * 4 + off), '0);
                issue_op(`EXE_LD_BU_OP, 1'b1, 8'(w * 4 + off), '0);
            end
        end
        for (int w = 0; w < 2; w++) begin
            for (int off = 0; off < 4; off++) begin
                issue_op(`EXE_LD_H_OP, 1'b1, 8'(w * 4 + off), '0); // odd offsets read zero.
            end
        end
        for (int off = 0; off < 4; off++) begin
            issue_op(`EXE_LD_W_OP, 1'b1, 8'(16 + off), '0);
            issue_op(`EXE_LL_OP, 1'b1, 8'(20 + off), '0);
        end

        // load right behind a store to the same word.
        for (int i = 0; i < 4; i++) begin
            a = 8'($random(seed));
            wait_credits(2);
            issue_op(`EXE_ST_B_OP, 1'b0, a, word_t'($random(seed)));
            issue_op(`EXE_LD_W_OP, 1'b1, a, '0);
            wait_credits(2);
            issue_op(`EXE_ST_H_OP, 1'b0, a & 8'hfe, word_t'($random(seed)));
            issue_op(`EXE_LD_H_OP, 1'b1, a & 8'hfe, '0);
        end

        // misaligned stores must leave the word alone.
        for (int off = 1; off < 4; off++) begin
            issue_op(`EXE_ST_W_OP, 1'b0, 8'(32 + off), word_t'($random(seed)));
            issue_op(`EXE_LD_W_OP, 1'b1, 8'd32, '0);
        end
        for (int off = 1; off < 4; off += 2) begin
            issue_op(`EXE_ST_H_OP, 1'b0, 8'(36 + off), word_t'($random(seed)));
            issue_op(`EXE_LD_W_OP, 1'b1, 8'd36, '0);
        end

        for (int i = 0; i < 8; i++) begin
            issue_op(`EXE_ALU_OP, (i % 2) == 0, 8'h00, '0);
        end

        ////////////////////
        // writeback stall, then a burst

        while (credits != `MEM_CREDITS) begin
            idle_cycles(1);
        end
        wb_pause = 1'b1;
        // use up writeback credits still held in the queue.
        while (grants != beats) begin
            issue_op(`EXE_ALU_OP, 1'b1, 8'h00, '0);
            wait_credits(`MEM_CREDITS);
        end
        for (int i = 0; i < `MEM_CREDITS; i++) begin
            issue_op(`EXE_LD_W_OP, 1'b1, 8'($random(seed)), '0);
        end
        idle_cycles(60);
        wb_pause = 1'b0;

        for (int i = 0; i < N_RAND; i++) begin
            wr = 1'b1;
            case ($unsigned($random(seed)) % 9)
                0: op = `EXE_LD_B_OP;
                1: op = `EXE_LD_BU_OP;
                2: op = `EXE_LD_H_OP;
                3: op = `EXE_LD_W_OP;
                4: op = `EXE_LL_OP;
                5: begin
                    op = `EXE_ST_B_OP;
                    wr = 1'b0;
                end
                6: begin
                    op = `EXE_ST_H_OP;
                    wr = 1'b0;
                end
                7: begin
                    op = `EXE_ST_W_OP;
                    wr = 1'b0;
                end
                default: begin
                    op = `EXE_ALU_OP;
                    wr = 1'($random(seed));
                end
            endcase
            a = 8'($random(seed)) & 8'h3f; // 16 words, so stores and loads collide.
            issue_op(op, wr, a, word_t'($random(seed)));
        end

        while (exp_waddr.size() != 0 || credits != `MEM_CREDITS) begin
            idle_cycles(1);
        end
        idle_cycles(8); // room for a stray late credit.
        if (credit_pulses != issued) begin
            $display("ERROR: %0d issue credits returned for %0d operations",
                     credit_pulses, issued);
            errors++;
        end
        if (fwd_waddr_q.size() != 0) begin
            $display("ERROR: %0d results never seen on the forwarding bundle",
                     fwd_waddr_q.size());
            errors++;
        end

        print_summary();
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+logic
logic/mem_pkg.sv
logic/mem1_stage.sv
logic/data_ram.sv
logic/mem2_stage.sv
logic/result_fifo.sv
logic/mem_top.sv
tests/mem_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module mem_tb -f filelist.f

# the simulation result is judged from its output below.
out=$(./obj_dir/Vmem_tb || true)
echo "$out"

if echo "$out" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
exit 1
